// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Datapath and bus widths
    localparam int xlen        = 64;           // Address and PC width
    localparam int mem_data_w  = 64;           // One SRAM word
    localparam int ibuf_w      = 32;           // Widest instruction handed to decode
    localparam int ferr_w      = ibuf_w / 16;  // One error bit per halfword of s1_instr
    localparam int buf_depth_w = 5;            // Byte count 0..16

    // Where fetch starts out of reset unless the top says otherwise
    localparam logic [xlen-1:0] pc_reset_default = 64'h8000_0000;

    // How many top bytes of an arriving word go into the buffer.
    // A redirect into the middle of a word keeps only the bytes at
    // and above the target; a sequential word is kept whole.
    typedef enum logic [2:0] {
        FILL_NONE,  // Nothing loaded
        FILL_2,     // Target at byte offset 6
        FILL_4,     // Target at byte offset 4
        FILL_6,     // Target at byte offset 2
        FILL_8      // Aligned target or sequential word
    } fill_mode_t;

endpackage

`default_nettype wire

// File: imem_if.sv
`timescale 1ns/1ns
`default_nettype none

// Instruction SRAM bus between fetch and memory
interface imem_if;
    import fetch_pkg::*;

    logic                  req;    // Fetch wants a word
    logic                  gnt;    // Memory takes it this cycle
    logic [xlen-1:0]       addr;   // Low 3 bits ignored by the SRAM
    logic [mem_data_w-1:0] rdata;  // Valid one cycle after req && gnt
    logic                  err;    // Address fell outside the SRAM

    // Fetch side
    modport req_mp (output req, output addr, input gnt, input rdata, input err);

    // Memory side
    modport rsp_mp (input req, input addr, output gnt, output rdata, output err);

endinterface

`default_nettype wire

// File: fetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer (
    input  logic                              g_clk,
    input  logic                              g_resetn,
    input  logic                              flush,      // Drop every held byte
    input  logic                              fill_en,    // data_in carries a word
    input  fetch_pkg::fill_mode_t             fill_mode,  // Top bytes of data_in to keep
    input  logic [fetch_pkg::mem_data_w-1:0]  data_in,
    input  logic                              error_in,   // Word came back with bus error
    input  logic                              drain_2,    // 16-bit instruction consumed
    input  logic                              drain_4,    // 32-bit instruction consumed
    output logic [fetch_pkg::buf_depth_w-1:0] depth,      // Bytes held now
    output logic [fetch_pkg::buf_depth_w-1:0] n_depth,    // Bytes held after this edge
    output logic [fetch_pkg::ibuf_w-1:0]      data_out,   // Head of the buffer
    output logic [fetch_pkg::ferr_w-1:0]      error_out   // Tags of the two head halfwords
);

    import fetch_pkg::*;

    localparam int buf_bytes = 16;
    localparam int buf_hw    = buf_bytes / 2;

    logic [buf_bytes*8-1:0] data_q;     // Byte 0 is the head, unused bytes kept zero
    logic [buf_hw-1:0]      err_q;      // One tag per halfword, zero above depth
    logic [buf_depth_w-1:0] depth_q;

    logic [buf_depth_w-1:0] drain_b;    // Bytes leaving at the head
    logic [buf_depth_w-1:0] fill_b;     // Bytes entering at the tail
    logic [buf_depth_w-1:0] kept_b;     // Bytes left once the head is gone
    logic [mem_data_w-1:0]  fill_data;  // Kept top bytes moved down to bit 0
    logic [buf_hw-1:0]      fill_err;
    logic [buf_bytes*8-1:0] n_data;
    logic [buf_hw-1:0]      n_err;

    // --------------------
    // Drain and fill sizes

    assign drain_b = drain_4 ? 5'd4 : (drain_2 ? 5'd2 : 5'd0);
    assign kept_b  = depth_q - drain_b;

    always_comb begin
        fill_b = '0;
        if (fill_en) begin
            case (fill_mode)
                FILL_2:  fill_b = 5'd2;
                FILL_4:  fill_b = 5'd4;
                FILL_6:  fill_b = 5'd6;
                FILL_8:  fill_b = 5'd8;
                default: fill_b = 5'd0;
            endcase
        end
    end

    // Shift by 64 when nothing is kept, which leaves zero
    assign fill_data = data_in >> {5'd8 - fill_b, 3'b000};

    always_comb begin
        fill_err = '0;
        if (error_in) begin
            fill_err = (buf_hw'(1) << fill_b[buf_depth_w-1:1]) - buf_hw'(1); // Tag every halfword
        end
    end

    // --------------------
    // Next buffer contents

    // Head drops out, new bytes land just above what is left
    assign n_data = (data_q >> {drain_b, 3'b000}) |
                    ({{(buf_bytes*8-mem_data_w){1'b0}}, fill_data} << {kept_b, 3'b000});
    assign n_err  = (err_q >> drain_b[buf_depth_w-1:1]) |
                    (fill_err << kept_b[buf_depth_w-1:1]);

    assign n_depth = flush ? '0 : kept_b + fill_b;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            data_q  <= '0;
            err_q   <= '0;
            depth_q <= '0;
        end else if (flush) begin
            data_q  <= '0;                // Old path bytes gone, tail back at byte 0
            err_q   <= '0;
            depth_q <= '0;
        end else begin
            data_q  <= n_data;
            err_q   <= n_err;
            depth_q <= n_depth;
        end
    end

    assign depth     = depth_q;
    assign data_out  = data_q[ibuf_w-1:0];
    assign error_out = err_q[ferr_w-1:0];

    // Fetch flow control must never push past 16 bytes
    assert property (@(posedge g_clk) disable iff (!g_resetn) n_depth <= buf_bytes)
        else $error("fetch_buffer: overflow, n_depth %0d", n_depth);

endmodule

`default_nettype wire

// File: imem_sram.sv
`timescale 1ns/1ns
`default_nettype none

module imem_sram #(
    parameter logic [fetch_pkg::xlen-1:0] PC_RESET_ADDRESS = fetch_pkg::pc_reset_default,
    parameter int                         MEM_WORDS        = 64
) (
    input  logic                             g_clk,
    input  logic                             g_resetn,
    imem_if.rsp_mp                           bus,
    input  logic                             stall,      // Hold off grants
    input  logic                             load_en,    // Write one word of the image
    input  logic [fetch_pkg::xlen-1:0]       load_addr,
    input  logic [fetch_pkg::mem_data_w-1:0] load_data
);

    import fetch_pkg::*;

    localparam int              idx_w     = $clog2(MEM_WORDS);
    localparam logic [xlen-1:0] mem_bytes = xlen'(MEM_WORDS * 8);

    logic [mem_data_w-1:0] mem [MEM_WORDS];
    logic [xlen-1:0]       rd_off;     // Byte offset from the base
    logic [xlen-1:0]       ld_off;
    logic                  rd_hit;
    logic                  ld_hit;
    logic                  rsp_valid;  // rdata and err belong to a grant

    // Below the base wraps to a huge offset and misses too
    assign rd_off  = bus.addr - PC_RESET_ADDRESS;
    assign ld_off  = load_addr - PC_RESET_ADDRESS;
    assign rd_hit  = rd_off < mem_bytes;
    assign ld_hit  = ld_off < mem_bytes;
    assign bus.gnt = !stall;

    always_ff @(posedge g_clk) begin
        if (load_en && ld_hit) begin
            mem[ld_off[idx_w+2:3]] <= load_data;
        end
    end

    // Word read on the grant, returned the next cycle
    always_ff @(posedge g_clk) begin
        if (bus.req && bus.gnt) begin
            bus.rdata <= rd_hit ? mem[rd_off[idx_w+2:3]] : '0;
            bus.err   <= !rd_hit;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= bus.req && bus.gnt;
        end
    end

    // A granted read comes back with a defined word and tag
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        rsp_valid |-> !$isunknown({bus.err, bus.rdata}))
        else $error("imem_sram: response with undefined data");

    // Fetch keeps a stalled request up with the same address
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        bus.req && stall |=> bus.req && $stable(bus.addr))
        else $error("imem_sram: request changed while stalled");

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
    parameter logic [fetch_pkg::xlen-1:0] PC_RESET_ADDRESS = fetch_pkg::pc_reset_default
) (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  logic                         cf_valid,   // Control flow change wanted
    output logic                         cf_ack,     // Change can be taken this cycle
    input  logic [fetch_pkg::xlen-1:0]   cf_target,  // Halfword aligned destination
    imem_if.req_mp                       imem,       // Instruction SRAM bus
    output logic                         s1_16bit,   // 16-bit instruction at the head
    output logic                         s1_32bit,   // 32-bit instruction at the head
    output logic [fetch_pkg::ibuf_w-1:0] s1_instr,
    output logic [fetch_pkg::xlen-1:0]   s1_pc,
    output logic [fetch_pkg::xlen-1:0]   s1_npc,
    output logic [fetch_pkg::ferr_w-1:0] s1_ferr,    // Bus error per halfword
    input  logic                         eat_2,      // Decode takes 2 bytes
    input  logic                         eat_4       // Decode takes 4 bytes
);

    import fetch_pkg::*;

    // Offset inside the word decides how much of the first word is usable
    function automatic fill_mode_t first_fill(input logic [2:0] offset);
        case (offset)
            3'd0:    return FILL_8;
            3'd2:    return FILL_6;
            3'd4:    return FILL_4;
            3'd6:    return FILL_2;
            default: return FILL_NONE;
        endcase
    endfunction

    logic                   e_cf_change;   // Redirect taken
    logic                   e_imem_req;    // Request granted
    logic                   req_q;
    logic [xlen-1:0]        addr_q;
    logic                   recv_q;        // Response on the bus this cycle
    logic [1:0]             out_q;         // Granted, data not back yet
    logic [1:0]             n_out;
    logic [1:0]             ign_q;         // Stale responses still to drop
    fill_mode_t             first_mode_q;  // Mode for the next granted word
    fill_mode_t             rsp_mode_q;    // Mode for the word now on the bus
    logic                   buf_ready;
    logic                   buf_fill_en;
    logic                   buf_drain_2;
    logic                   buf_drain_4;
    logic [buf_depth_w-1:0] buf_depth;
    logic [buf_depth_w-1:0] n_buf_depth;
    logic [ibuf_w-1:0]      buf_data;
    logic [ferr_w-1:0]      buf_err;

    assign e_cf_change = cf_valid && cf_ack;
    assign e_imem_req  = req_q && imem.gnt;
    assign cf_ack      = !req_q || imem.gnt;  // No request left waiting

    // --------------------
    // Fetch requests

    assign n_out = out_q + {1'b0, e_imem_req} - {1'b0, recv_q};

    // Room for held bytes, every word in flight and one word more
    assign buf_ready = ({1'b0, n_buf_depth} + {1'b0, n_out, 3'b000}) <= 6'd8;

    assign imem.req  = req_q;
    assign imem.addr = addr_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            req_q  <= 1'b0;
            recv_q <= 1'b0;
            addr_q <= PC_RESET_ADDRESS;
        end else begin
            req_q  <= (req_q && !imem.gnt) || buf_ready;  // Held until granted
            recv_q <= e_imem_req;
            if (e_cf_change) begin
                addr_q <= cf_target;                    // Beats a same-cycle grant
            end else if (e_imem_req) begin
                addr_q <= addr_q + xlen'(8);
            end
        end
    end

    // --------------------
    // Outstanding and stale responses

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            out_q <= 2'd0;
            ign_q <= 2'd0;
        end else begin
            out_q <= n_out;
            if (e_cf_change) begin
                ign_q <= n_out;                 // All of it is old path
            end else if (recv_q && ign_q != 2'd0) begin
                ign_q <= ign_q - 2'd1;
            end
        end
    end

    // First word after a redirect is partial, the rest are whole
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            first_mode_q <= first_fill(PC_RESET_ADDRESS[2:0]);
            rsp_mode_q   <= FILL_NONE;
        end else begin
            rsp_mode_q <= e_imem_req ? first_mode_q : FILL_NONE;
            if (e_cf_change) begin
                first_mode_q <= first_fill(cf_target[2:0]);
            end else if (e_imem_req) begin
                first_mode_q <= FILL_8;
            end
        end
    end

    // --------------------
    // Program counter

    assign s1_npc = s1_pc + {{(xlen-3){1'b0}}, s1_32bit, s1_16bit, 1'b0};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s1_pc <= PC_RESET_ADDRESS;
        end else if (e_cf_change) begin
            s1_pc <= cf_target;
        end else if (buf_drain_2 || buf_drain_4) begin
            s1_pc <= s1_npc;
        end
    end

    // --------------------
    // Buffer and decode side

    assign buf_fill_en = recv_q && (ign_q == 2'd0) && !e_cf_change;
    assign buf_drain_2 = s1_16bit && eat_2;
    assign buf_drain_4 = s1_32bit && eat_4;

    // Low bits 11 mark a 32-bit encoding
    assign s1_16bit = (buf_depth >= 5'd2) && (buf_data[1:0] != 2'b11);
    assign s1_32bit = (buf_depth >= 5'd4) && (buf_data[1:0] == 2'b11);
    assign s1_instr = buf_data;
    assign s1_ferr  = buf_err;

    fetch_buffer u_buffer (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (e_cf_change),
        .fill_en   (buf_fill_en),
        .fill_mode (rsp_mode_q),
        .data_in   (imem.rdata),
        .error_in  (imem.err),
        .drain_2   (buf_drain_2),
        .drain_4   (buf_drain_4),
        .depth     (buf_depth),
        .n_depth   (n_buf_depth),
        .data_out  (buf_data),
        .error_out (buf_err)
    );

    // Decode only takes what it was offered
    assert property (@(posedge g_clk) disable iff (!g_resetn) eat_2 |-> s1_16bit)
        else $error("fetch_stage: eat_2 without s1_16bit");
    assert property (@(posedge g_clk) disable iff (!g_resetn) eat_4 |-> s1_32bit)
        else $error("fetch_stage: eat_4 without s1_32bit");

    // Words in flight always have room behind the held bytes
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        ({1'b0, buf_depth} + {1'b0, out_q, 3'b000}) <= 6'd16)
        else $error("fetch_stage: %0d words in flight with %0d bytes held", out_q, buf_depth);

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter logic [fetch_pkg::xlen-1:0] PC_RESET_ADDRESS = fetch_pkg::pc_reset_default,
    parameter int                         MEM_WORDS        = 64
) (
    input  logic                             g_clk,
    input  logic                             g_resetn,

    // Control flow change
    input  logic                             cf_valid,
    output logic                             cf_ack,
    input  logic [fetch_pkg::xlen-1:0]       cf_target,

    input  logic                             imem_stall,  // Holds off SRAM grants

    // Image load port
    input  logic                             load_en,
    input  logic [fetch_pkg::xlen-1:0]       load_addr,
    input  logic [fetch_pkg::mem_data_w-1:0] load_data,

    // Decode side
    output logic                             s1_16bit,
    output logic                             s1_32bit,
    output logic [fetch_pkg::ibuf_w-1:0]     s1_instr,
    output logic [fetch_pkg::xlen-1:0]       s1_pc,
    output logic [fetch_pkg::xlen-1:0]       s1_npc,
    output logic [fetch_pkg::ferr_w-1:0]     s1_ferr,
    input  logic                             eat_2,
    input  logic                             eat_4
);

    imem_if u_imem ();  // Fetch to SRAM

    // SRAM base sits at the reset vector
    imem_sram #(
        .PC_RESET_ADDRESS (PC_RESET_ADDRESS),
        .MEM_WORDS        (MEM_WORDS)
    ) u_sram (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .bus       (u_imem),
        .stall     (imem_stall),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    fetch_stage #(
        .PC_RESET_ADDRESS (PC_RESET_ADDRESS)
    ) u_fetch (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_valid  (cf_valid),
        .cf_ack    (cf_ack),
        .cf_target (cf_target),
        .imem      (u_imem),
        .s1_16bit  (s1_16bit),
        .s1_32bit  (s1_32bit),
        .s1_instr  (s1_instr),
        .s1_pc     (s1_pc),
        .s1_npc    (s1_npc),
        .s1_ferr   (s1_ferr),
        .eat_2     (eat_2),
        .eat_4     (eat_4)
    );

endmodule

`default_nettype wire

// File: fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

    import fetch_pkg::*;

    localparam logic [xlen-1:0] base      = pc_reset_default;  // SRAM base and reset vector
    localparam int              mem_words = 64;
    localparam int              half_per  = 20;                 // 40 ns clock

    logic                  g_clk;
    logic                  g_resetn;
    logic                  cf_valid;
    logic                  cf_ack;
    logic [xlen-1:0]       cf_target;
    logic                  imem_stall;
    logic                  load_en;
    logic [xlen-1:0]       load_addr;
    logic [mem_data_w-1:0] load_data;
    logic                  s1_16bit;
    logic                  s1_32bit;
    logic [ibuf_w-1:0]     s1_instr;
    logic [xlen-1:0]       s1_pc;
    logic [xlen-1:0]       s1_npc;
    logic [ferr_w-1:0]     s1_ferr;
    logic                  eat_2;
    logic                  eat_4;

    logic [mem_data_w-1:0] image [mem_words];  // Reference copy of the SRAM
    string                 t_name [$];
    int                    t_redir [$];
    logic [xlen-1:0]       t_target [$];
    int                    t_cycles [$];
    int                    t_stall [$];
    int                    t_eat [$];
    string                 cur_name;
    logic [xlen-1:0]       exp_pc;        // Address of the next instruction due
    logic [xlen-1:0]       redir_target;
    logic                  redir_pend;    // Redirect offered, not yet taken
    int                    n_seen;        // Instructions presented in this test
    int                    n_checks;
    int                    n_errors;
    int                    wd_cycles;     // Stays 0 until the test file is read

    fetch_top #(.PC_RESET_ADDRESS(base), .MEM_WORDS(mem_words)) u_dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #half_per g_clk = ~g_clk;
    end

    // --------------------
    // Reference memory

    function automatic logic in_sram(input logic [xlen-1:0] a);
        return (a - base) < xlen'(mem_words * 8);  // Below base wraps and misses
    endfunction

    function automatic int word_index(input logic [xlen-1:0] a);
        return int'((a - base) >> 3);
    endfunction

    function automatic logic [15:0] mem_hw(input logic [xlen-1:0] a);
        logic [mem_data_w-1:0] word;
        word = image[word_index(a)];
        return word[{a[2:1], 4'b0000} +: 16];  // Little-endian halfword
    endfunction

    // Every word differs, upper address bits folded in
    function automatic logic [mem_data_w-1:0] fill_word(input logic [xlen-1:0] a);
        return {a[31:0] * 32'h9e3779b9, a[63:32] ^ a[31:0] ^ 32'hc3a55a3c};
    endfunction

    task automatic check(input string what, input logic [xlen-1:0] exp,
                         input logic [xlen-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        n_errors++;
        $display("error in %s: %s", cur_name, msg);
    endtask

    task automatic read_tests();
        int                    fd;
        int                    n;
        string                 line;
        string                 kind;
        string                 nm;
        logic [xlen-1:0]       a;
        logic [mem_data_w-1:0] d;
        int                    rd;
        int                    cy;
        int                    st;
        int                    et;
        fd = $fopen("fetch_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open fetch_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            kind = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", kind);  // Comment lines give "#"
            if (kind == "load") begin
                n = $sscanf(line, "%s %h %h", kind, a, d);
                if (in_sram(a)) image[word_index(a)] = d;
                else report_failure("load address outside the SRAM");
            end else if (kind == "test") begin
                n = $sscanf(line, "%s %s %d %h %d %d %d", kind, nm, rd, a, cy, st, et);
                t_name.push_back(nm);
                t_redir.push_back(rd);
                t_target.push_back(a);
                t_cycles.push_back(cy);
                t_stall.push_back(st);
                t_eat.push_back(et);
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // One cycle, called on the falling edge

    task automatic step(input int stall_pct, input int eat_pct);
        logic            is32;
        logic [xlen-1:0] len;
        logic [15:0]     hw0;
        logic [15:0]     hw1;
        eat_2     = 1'b0;
        eat_4     = 1'b0;
        cf_valid  = redir_pend;
        cf_target = redir_target;
        check("s1_pc", exp_pc, s1_pc);
        if (s1_16bit || s1_32bit) begin
            hw0 = s1_instr[15:0];  // Outside the SRAM only the length rule applies
            if (in_sram(exp_pc)) begin
                hw0 = mem_hw(exp_pc);
                check("s1_instr[15:0]", hw0, s1_instr[15:0]);
            end
            is32 = hw0[1:0] == 2'b11;  // Low bits 11 mean 32-bit
            check("s1_32bit", is32, s1_32bit);
            check("s1_16bit", !is32, s1_16bit);
            check("s1_ferr[0]", !in_sram(exp_pc), s1_ferr[0]);
            if (is32) begin
                if (in_sram(exp_pc + 2)) begin
                    hw1 = mem_hw(exp_pc + 2);
                    check("s1_instr[31:16]", hw1, s1_instr[31:16]);
                end
                check("s1_ferr[1]", !in_sram(exp_pc + 2), s1_ferr[1]);
            end
            len = is32 ? 4 : 2;
            check("s1_npc", exp_pc + len, s1_npc);
            n_seen++;
            if (($urandom % 100) < eat_pct) begin
                eat_2  = s1_16bit;
                eat_4  = s1_32bit;
                exp_pc = exp_pc + len;
            end
        end
        imem_stall = ($urandom % 100) < stall_pct;
        #1;
        // A waiting request blocks the redirect
        if (u_dut.u_imem.req && imem_stall) check("cf_ack while stalled", 0, cf_ack);
        if (redir_pend && cf_ack) begin
            redir_pend = 1'b0;
            exp_pc     = redir_target;  // Taken on the coming edge
        end
    endtask

    // --------------------
    // Main sequence

    initial begin
        int total;
        void'($urandom(32'h662a9fca));
        g_resetn     = 1'b0;
        cf_valid     = 1'b0;
        cf_target    = '0;
        imem_stall   = 1'b1;  // No grants until the image is loaded
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        eat_2        = 1'b0;
        eat_4        = 1'b0;
        n_checks     = 0;
        n_errors     = 0;
        n_seen       = 0;
        wd_cycles    = 0;
        redir_pend   = 1'b0;
        redir_target = '0;
        cur_name     = "setup";
        exp_pc       = base;
        for (int i = 0; i < mem_words; i++) image[i] = fill_word(base + xlen'(8 * i));
        read_tests();
        total = 0;
        foreach (t_cycles[i]) total += t_cycles[i];
        wd_cycles = 20 * total;
        repeat (10) @(negedge g_clk);
        g_resetn = 1'b1;
        for (int i = 0; i < mem_words; i++) begin
            @(negedge g_clk);
            load_en   = 1'b1;
            load_addr = base + xlen'(8 * i);
            load_data = image[i];
        end
        @(negedge g_clk);
        load_en = 1'b0;
        foreach (t_name[t]) begin
            cur_name     = t_name[t];
            n_seen       = 0;
            redir_pend   = t_redir[t] != 0;
            redir_target = t_target[t];
            repeat (t_cycles[t]) begin
                @(negedge g_clk);
                step(t_stall[t], t_eat[t]);
            end
            if (redir_pend) report_failure("redirect was never accepted");
            if (n_seen == 0) report_failure("no instruction was presented");
        end
        @(negedge g_clk);
        cf_valid = 1'b0;
        eat_2    = 1'b0;
        eat_4    = 1'b0;
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog, budget set from the test file
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge g_clk);
        $display("watchdog expired: run still going after %0d cycles", wd_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_tests.txt
# load <byte address hex> <64-bit word hex>
# test <name> <redirect 0/1> <target hex> <cycles> <stall percent> <eat percent>
load 80000000 0513450100000297
load 80000008 0593000180820000
load 80000010 00a500b346050010
load 80000018 bf7d000003179502
load 80000020 00e7056303b14581
load 80000028 fff0051300010001
test seq_reset 0 0 60 0 100
test mixed_slow_eat 0 0 60 0 40
test redir_off0 1 80000040 30 0 100
test redir_off2 1 8000004a 30 0 100
test redir_off4 1 80000104 30 0 100
test redir_off6 1 8000001e 30 0 100
test redir_in_flight 1 80000008 20 0 100
test redir_to_start 1 80000000 30 0 100
test out_of_range 1 80000400 20 0 100
test back_in_range 1 80000002 40 0 100
test rand_stall_eat 1 80000000 150 40 60
test rand_stall_tail 1 80000100 150 60 50

// File: build.f
fetch_pkg.sv
imem_if.sv
fetch_buffer.sv
imem_sram.sv
fetch_stage.sv
fetch_top.sv
fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - fetch_pkg.sv
  - imem_if.sv
  - fetch_buffer.sv
  - imem_sram.sv
  - fetch_stage.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_tb.sv
